//--- testbench/wb_vectors.txt
# mem_in: wd wreg wdata whilo hi lo pc cp0_we cp0_waddr cp0_wdata delayslot except_type mem_addr
# then stall raddr1 raddr2 cp0_raddr, expected rdata1 rdata2 hi lo cp0_rdata flush timer_int, mask
# all hex, one clock cycle per line, mask bit 0 is rdata1 up to bit 6 timer_int
1 1 11111111 0 0 0 bfc00000 1 b 4 0 0 0 0 0 0 c 0 0 0 0 400000 0 0 7f
0 1 deadbeef 1 a5a5a5a5 5a5a5a5a bfc00004 0 0 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0 7f
2 1 22222222 0 ffffffff ffffffff bfc00008 0 0 0 0 0 0 0 1 0 b 11111111 0 0 0 4 0 0 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 b 11111111 0 a5a5a5a5 5a5a5a5a 4 0 0 7f
3 1 33333333 0 0 0 bfc0000c 0 0 0 0 0 0 0 2 1 b 22222222 11111111 a5a5a5a5 5a5a5a5a 4 0 0 7f
3 1 bad0bad0 0 0 0 bfc00010 0 0 0 0 0 0 1 2 1 b 22222222 11111111 a5a5a5a5 5a5a5a5a 4 0 0 7f
4 1 40404040 0 0 0 bfc00014 0 0 0 0 0 0 0 3 2 b 33333333 22222222 a5a5a5a5 5a5a5a5a 4 0 0 7f
5 1 50505050 0 0 0 bfc00018 0 0 0 0 0 0 0 3 2 b 33333333 22222222 a5a5a5a5 5a5a5a5a 4 0 0 3f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 4 b 33333333 40404040 a5a5a5a5 5a5a5a5a 4 0 0 3f
4 1 44444444 0 0 0 bfc00020 0 0 0 0 4 1003 0 4 5 e 40404040 50505050 a5a5a5a5 5a5a5a5a 0 0 0 3f
5 1 55555555 0 0 0 bfc00024 0 0 0 0 0 0 0 4 5 e 40404040 50505050 a5a5a5a5 5a5a5a5a 0 1 0 3f
4 1 dddddddd 0 0 0 bfc00028 0 0 0 0 0 0 0 4 5 e 40404040 50505050 a5a5a5a5 5a5a5a5a bfc00020 1 0 3f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 d 40404040 50505050 a5a5a5a5 5a5a5a5a 8010 0 1 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 8 40404040 50505050 a5a5a5a5 5a5a5a5a 1003 0 1 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 c 40404040 50505050 a5a5a5a5 5a5a5a5a 400002 0 1 7f
6 1 66666666 0 0 0 bfc00104 0 0 0 1 c 2000 0 4 5 e 40404040 50505050 a5a5a5a5 5a5a5a5a bfc00020 0 1 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 e 40404040 50505050 a5a5a5a5 5a5a5a5a bfc00020 1 1 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 e 40404040 50505050 a5a5a5a5 5a5a5a5a bfc00100 1 1 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 d 40404040 50505050 a5a5a5a5 5a5a5a5a 80008030 0 1 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 8 40404040 50505050 a5a5a5a5 5a5a5a5a 1003 0 1 7f
0 0 0 0 0 0 bfc00108 1 c ff01 0 0 0 0 4 5 c 40404040 50505050 a5a5a5a5 5a5a5a5a 400002 0 1 7f
0 0 0 0 0 0 bfc0010c 1 b 1000 0 0 0 0 4 5 c 40404040 50505050 a5a5a5a5 5a5a5a5a 400002 0 1 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 c 40404040 50505050 a5a5a5a5 5a5a5a5a ff01 0 1 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 d 40404040 50505050 a5a5a5a5 5a5a5a5a 80000030 0 0 7f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 b 40404040 50505050 a5a5a5a5 5a5a5a5a 1000 0 0 7f

//--- verilog.f
verilog/cpu_types_pkg.sv
verilog/cp0_defs_pkg.sv
verilog/mem_wb.sv
verilog/wb_ctrl.sv
verilog/cp0_timer.sv
verilog/cp0_regs.sv
verilog/arch_regs.sv
verilog/wb_stage_top.sv
testbench/tb_wb_stage.sv

//--- Bender.yml
package:
  name: wb_stage

sources:
  - verilog/cpu_types_pkg.sv
  - verilog/cp0_defs_pkg.sv
  - verilog/mem_wb.sv
  - verilog/wb_ctrl.sv
  - verilog/cp0_timer.sv
  - verilog/cp0_regs.sv
  - verilog/arch_regs.sv
  - verilog/wb_stage_top.sv
  - target: test
    files:
      - testbench/tb_wb_stage.sv

//--- testbench/tb_wb_stage.sv
`timescale 1ns/100ps

module tb_wb_stage
    import cpu_types_pkg::*;
    import cp0_defs_pkg::*;
();

    // one line of the vectors file
    typedef struct packed {
        mem_wb_t    mem;
        logic       stall;
        reg_addr_t  raddr1;
        reg_addr_t  raddr2;
        cp0_addr_t  cp0_raddr;
        word_t      rdata1;
        word_t      rdata2;
        word_t      hi;
        word_t      lo;
        word_t      cp0_rdata;
        logic       flush;
        logic       timer_int;
        logic [6:0] mask;       // one bit per expected field starting with rdata1 in bit 0
    } vector_t;

    logic       clk;
    logic       arst_n;
    mem_wb_t    mem_in;
    logic       stall;
    reg_addr_t  raddr1;
    reg_addr_t  raddr2;
    cp0_addr_t  cp0_raddr;
    word_t      rdata1;
    word_t      rdata2;
    word_t      hi;
    word_t      lo;
    word_t      cp0_rdata;
    logic       flush;
    inst_addr_t exc_pc;
    logic       timer_int;

    vector_t vectors [$];
    int      errors = 0;
    int      cycles = 0;
    int      limit  = 0;

    wb_stage_top uut (
        .clk(clk), .arst_n(arst_n), .mem_in(mem_in), .stall(stall),
        .raddr1(raddr1), .raddr2(raddr2), .cp0_raddr(cp0_raddr),
        .rdata1(rdata1), .rdata2(rdata2), .hi(hi), .lo(lo), .cp0_rdata(cp0_rdata),
        .flush(flush), .exc_pc(exc_pc), .timer_int(timer_int)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the vectors did not run to the end", cycles);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // vectors and checks
    ////////////////////////////////////////

    task automatic load_vectors();
        int      fd;
        int      n;
        string   line;
        word_t   f [25];
        vector_t v;
        fd = $fopen("testbench/wb_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vectors file testbench/wb_vectors.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue; // blank or column notes
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                        f[19], f[20], f[21], f[22], f[23], f[24]);
            if (n != 25) begin
                $display("vectors file line has %0d fields instead of 25: %s", n, line);
                errors++;
                continue;
            end
            v = '0;
            v.mem.wd           = f[0][4:0];
            v.mem.wreg         = f[1][0];
            v.mem.wdata        = f[2];
            v.mem.whilo        = f[3][0];
            v.mem.hi           = f[4];
            v.mem.lo           = f[5];
            v.mem.pc           = f[6];
            v.mem.cp0_we       = f[7][0];
            v.mem.cp0_waddr    = f[8][4:0];
            v.mem.cp0_wdata    = f[9];
            v.mem.in_delayslot = f[10][0];
            v.mem.except_type  = f[11];
            v.mem.mem_addr     = f[12];
            v.stall            = f[13][0];
            v.raddr1           = f[14][4:0];
            v.raddr2           = f[15][4:0];
            v.cp0_raddr        = f[16][4:0];
            v.rdata1           = f[17];
            v.rdata2           = f[18];
            v.hi               = f[19];
            v.lo               = f[20];
            v.cp0_rdata        = f[21];
            v.flush            = f[22][0];
            v.timer_int        = f[23][0];
            v.mask             = f[24][6:0];
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("the vectors file testbench/wb_vectors.txt holds no vectors");
            errors++;
        end
    endtask

    task automatic apply_vector(input vector_t v);
        mem_in    = v.mem;
        stall     = v.stall;
        raddr1    = v.raddr1;
        raddr2    = v.raddr2;
        cp0_raddr = v.cp0_raddr;
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual,
                               input int idx);
        if (actual !== expected) begin
            errors++;
            $display("** Error vector %0d %s: expected %h, got %h", idx, name, expected, actual);
        end
    endtask

    task automatic compare_outputs(input vector_t v, input int idx);
        if (v.mask[0]) check_value("rdata1", v.rdata1, rdata1, idx);
        if (v.mask[1]) check_value("rdata2", v.rdata2, rdata2, idx);
        if (v.mask[2]) check_value("hi", v.hi, hi, idx);
        if (v.mask[3]) check_value("lo", v.lo, lo, idx);
        if (v.mask[4]) check_value("cp0_rdata", v.cp0_rdata, cp0_rdata, idx);
        if (v.mask[5]) begin
            check_value("flush", word_t'(v.flush), word_t'(flush), idx);
            // while flushing the pipeline is redirected to the handler
            if (v.flush) check_value("exc_pc", exc_vector, exc_pc, idx);
        end
        if (v.mask[6]) check_value("timer_int", word_t'(v.timer_int), word_t'(timer_int), idx);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int i;
        arst_n    = 1'b0;
        mem_in    = '0;
        stall     = 1'b0;
        raddr1    = '0;
        raddr2    = '0;
        cp0_raddr = '0;
        load_vectors();
        limit = vectors.size() + 20;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (i = 0; i < vectors.size(); i++) begin
            apply_vector(vectors[i]);
            #5; // outputs settle well before the next edge
            compare_outputs(vectors[i], i);
            @(posedge clk);
            #1;
        end
        $display("%0d vectors checked, %0d errors", vectors.size(), errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog/wb_stage_top.sv
`timescale 1ns/100ps

module wb_stage_top
    import cpu_types_pkg::*;
#(
    parameter int unsigned count_div    = 2,
    parameter word_t       reset_status = 32'h0040_0000
) (
    input  logic       clk,
    input  logic       arst_n,
    input  mem_wb_t    mem_in,
    input  logic       stall,
    input  reg_addr_t  raddr1,
    input  reg_addr_t  raddr2,
    input  cp0_addr_t  cp0_raddr,
    output word_t      rdata1,
    output word_t      rdata2,
    output word_t      hi,
    output word_t      lo,
    output word_t      cp0_rdata,
    output logic       flush,
    output inst_addr_t exc_pc,
    output logic       timer_int
);

    mem_wb_t wb;
    logic    commit;
    logic    take_exc;
    logic    count_we;
    logic    compare_we;
    word_t   count_wdata;
    word_t   compare_wdata;
    word_t   count;
    word_t   compare;

    mem_wb u_mem_wb (
        .clk(clk), .arst_n(arst_n), .en(!stall), .flush(flush),
        .mem_in(mem_in), .wb(wb)
    );

    wb_ctrl u_wb_ctrl (
        .clk(clk), .arst_n(arst_n), .wb(wb), .commit(commit),
        .take_exc(take_exc), .flush(flush), .exc_pc(exc_pc)
    );

    cp0_regs #(.reset_status(reset_status)) u_cp0_regs (
        .clk(clk), .arst_n(arst_n), .wb(wb), .commit(commit), .take_exc(take_exc),
        .count(count), .compare(compare), .timer_int(timer_int),
        .count_we(count_we), .count_wdata(count_wdata),
        .compare_we(compare_we), .compare_wdata(compare_wdata),
        .raddr(cp0_raddr), .rdata(cp0_rdata)
    );

    cp0_timer #(.count_div(count_div)) u_cp0_timer (
        .clk(clk), .arst_n(arst_n),
        .count_we(count_we), .count_wdata(count_wdata),
        .compare_we(compare_we), .compare_wdata(compare_wdata),
        .count(count), .compare(compare), .timer_int(timer_int)
    );

    arch_regs u_arch_regs (
        .clk(clk), .arst_n(arst_n), .wb(wb), .commit(commit),
        .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
        .hi(hi), .lo(lo)
    );

endmodule

//--- verilog/arch_regs.sv
`timescale 1ns/100ps

module arch_regs
    import cpu_types_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  mem_wb_t   wb,
    input  logic      commit,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    output word_t     hi,
    output word_t     lo
);

    word_t gpr [1:31]; // $0 has no storage

    always_ff @(posedge clk) begin
        if (commit && wb.wreg && wb.wd != '0) begin
            gpr[wb.wd] <= wb.wdata;
        end
    end

    // no bypass, a same-cycle write shows up after the edge
    assign rdata1 = (raddr1 == '0) ? '0 : gpr[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : gpr[raddr2];

    ////////////////////////////////////////
    // hi/lo pair
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (commit && wb.whilo) begin
            hi <= wb.hi;
            lo <= wb.lo;
        end
    end

endmodule

//--- verilog/cp0_regs.sv
`timescale 1ns/100ps

module cp0_regs
    import cpu_types_pkg::*;
    import cp0_defs_pkg::*;
#(
    parameter word_t reset_status = 32'h0040_0000
) (
    input  logic      clk,
    input  logic      arst_n,
    input  mem_wb_t   wb,
    input  logic      commit,
    input  logic      take_exc,
    input  word_t     count,
    input  word_t     compare,
    input  logic      timer_int,
    output logic      count_we,
    output word_t     count_wdata,
    output logic      compare_we,
    output word_t     compare_wdata,
    input  cp0_addr_t raddr,
    output word_t     rdata
);

    word_t      status;
    word_t      epc;
    word_t      badvaddr;
    logic       cause_bd;       // exception was in a delay slot
    logic [1:0] cause_ip_sw;    // software interrupt bits IP1..IP0
    logic [4:0] cause_exc_code;
    word_t      cause;
    logic       wr;
    logic [4:0] code;

    assign wr   = commit && wb.cp0_we;
    assign code = wb.except_type[4:0];

    // Count and Compare live in the timer
    assign count_we      = wr && (wb.cp0_waddr == cp0_count);
    assign count_wdata   = wb.cp0_wdata;
    assign compare_we    = wr && (wb.cp0_waddr == cp0_compare);
    assign compare_wdata = wb.cp0_wdata;

    ////////////////////////////////////////
    // register bank
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status         <= reset_status;
            epc            <= '0;
            badvaddr       <= '0;
            cause_bd       <= 1'b0;
            cause_ip_sw    <= '0;
            cause_exc_code <= '0;
        end else if (take_exc) begin
            status[1]      <= 1'b1; // EXL
            epc            <= wb.in_delayslot ? wb.pc - 32'd4 : wb.pc;
            cause_bd       <= wb.in_delayslot;
            cause_exc_code <= code;
            if (code == exc_adel || code == exc_ades) begin
                badvaddr <= wb.mem_addr;
            end
        end else if (wr) begin
            case (wb.cp0_waddr)
                cp0_status: status      <= wb.cp0_wdata;
                cp0_cause:  cause_ip_sw <= wb.cp0_wdata[9:8]; // only IP1..IP0 are writable
                cp0_epc:    epc         <= wb.cp0_wdata;
                default: ;
            endcase
        end
    end

    // IP7 follows the timer directly
    always_comb begin
        cause        = '0;
        cause[31]    = cause_bd;
        cause[15]    = timer_int;
        cause[9:8]   = cause_ip_sw;
        cause[6:2]   = cause_exc_code;
    end

    always_comb begin
        case (raddr)
            cp0_badvaddr: rdata = badvaddr;
            cp0_count:    rdata = count;
            cp0_compare:  rdata = compare;
            cp0_status:   rdata = status;
            cp0_cause:    rdata = cause;
            cp0_epc:      rdata = epc;
            default:      rdata = '0;
        endcase
    end

endmodule

//--- verilog/cp0_timer.sv
`timescale 1ns/100ps

module cp0_timer
    import cpu_types_pkg::*;
#(
    parameter int unsigned count_div = 2
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  count_we,
    input  word_t count_wdata,
    input  logic  compare_we,
    input  word_t compare_wdata,
    output word_t count,
    output word_t compare,
    output logic  timer_int
);

    localparam int unsigned div_w = (count_div > 1) ? $clog2(count_div) : 1;

    logic [div_w-1:0] pre;
    logic             tick;

    assign tick = (pre == div_w'(count_div - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre   <= '0;
            count <= '0;
        end else if (count_we) begin
            pre   <= '0; // restart the prescaler with the new count
            count <= count_wdata;
        end else begin
            pre <= tick ? '0 : pre + 1'b1;
            if (tick) begin
                count <= count + 1'b1;
            end
        end
    end

    // a zero Compare never fires, so the timer stays quiet after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            compare   <= '0;
            timer_int <= 1'b0;
        end else if (compare_we) begin
            compare   <= compare_wdata;
            timer_int <= 1'b0; // writing Compare acknowledges the interrupt
        end else if (compare != '0 && count == compare) begin
            timer_int <= 1'b1;
        end
    end

endmodule

//--- verilog/wb_ctrl.sv
`timescale 1ns/100ps

module wb_ctrl
    import cpu_types_pkg::*;
    import cp0_defs_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  mem_wb_t    wb,
    output logic       commit,
    output logic       take_exc,
    output logic       flush,
    output inst_addr_t exc_pc
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        exc;

    assign exc = (wb.except_type != '0);

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ctrl_run;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////
    // commit / trap decision
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        commit    = 1'b0;
        take_exc  = 1'b0;
        flush     = 1'b0;
        case (state)
            ctrl_run: begin
                if (exc) begin
                    take_exc  = 1'b1; // instruction traps instead of committing
                    flush     = 1'b1;
                    state_nxt = ctrl_flush;
                end else begin
                    commit = 1'b1;
                end
            end
            ctrl_flush: begin
                // second flush cycle, also drops whatever was sampled behind the trap
                flush     = 1'b1;
                state_nxt = ctrl_run;
            end
            default: begin
                state_nxt = ctrl_run;
            end
        endcase
    end

    // redirect address is only meaningful while flushing
    assign exc_pc = flush ? exc_vector : '0;

endmodule

//--- verilog/mem_wb.sv
`timescale 1ns/100ps

module mem_wb
    import cpu_types_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    en,
    input  logic    flush,
    input  mem_wb_t mem_in,
    output mem_wb_t wb
);

    // an all-zero entry is a bubble with no write and no exception
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else if (flush) begin
            wb <= '0; // flush wins over a stall
        end else if (en) begin
            wb <= mem_in;
        end
    end

endmodule

//--- verilog/cp0_defs_pkg.sv
package cp0_defs_pkg;

    ////////////////////////////////////////
    // cp0 register numbers
    ////////////////////////////////////////

    localparam logic [4:0] cp0_badvaddr = 5'd8;
    localparam logic [4:0] cp0_count    = 5'd9;
    localparam logic [4:0] cp0_compare  = 5'd11;
    localparam logic [4:0] cp0_status   = 5'd12;
    localparam logic [4:0] cp0_cause    = 5'd13;
    localparam logic [4:0] cp0_epc      = 5'd14;

    ////////////////////////////////////////
    // exception codes, as they land in Cause[6:2]
    ////////////////////////////////////////

    localparam logic [4:0] exc_adel    = 5'h04; // address error on load or fetch
    localparam logic [4:0] exc_ades    = 5'h05; // address error on store
    localparam logic [4:0] exc_syscall = 5'h08;
    localparam logic [4:0] exc_break   = 5'h09;
    localparam logic [4:0] exc_ov      = 5'h0c; // arithmetic overflow

    // general exception handler, EXL set and BEV clear
    localparam logic [31:0] exc_vector = 32'h8000_0180;

    typedef enum logic {
        ctrl_run,
        ctrl_flush
    } ctrl_state_t;

endpackage

//--- verilog/cpu_types_pkg.sv
package cpu_types_pkg;

    ////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////

    typedef logic [31:0] word_t;      // general data word
    typedef logic [4:0]  reg_addr_t;  // general register number
    typedef logic [31:0] inst_addr_t; // instruction address
    typedef logic [4:0]  cp0_addr_t;  // cp0 register number

    // bits [4:0] hold the exception code, zero means no exception
    typedef logic [31:0] except_t;

    ////////////////////////////////////////
    // one instruction travelling from MEM to WB
    ////////////////////////////////////////

    typedef struct packed {
        reg_addr_t  wd;           // destination gpr
        logic       wreg;         // gpr write enable
        word_t      wdata;
        logic       whilo;        // hi/lo write enable
        word_t      hi;
        word_t      lo;
        inst_addr_t pc;
        logic       cp0_we;
        cp0_addr_t  cp0_waddr;
        word_t      cp0_wdata;
        logic       in_delayslot;
        except_t    except_type;
        word_t      mem_addr;     // load/store address, feeds BadVAddr
    } mem_wb_t;

endpackage
